/* logic/mv_defs.svh */
`ifndef MV_DEFS_SVH
`define MV_DEFS_SVH

// data word width
`define MV_WORD_W 32

// weight row and vector length in words
`define MV_DEPTH 64

// words carried by one weight load beat
`define MV_BEAT_WORDS 8

// number of mac cores in the chain
`define MV_CORES 4

`endif

/* logic/mv_pkg.sv */
`default_nettype none
`include "mv_defs.svh"

package mv_pkg;

    typedef logic [`MV_WORD_W-1:0] mv_word_t;

    typedef logic [$clog2(`MV_DEPTH)-1:0] mv_addr_t;

    typedef logic [$clog2(`MV_CORES)-1:0] mv_core_t;

    // word 0 sits at the base address
    typedef logic [`MV_BEAT_WORDS-1:0][`MV_WORD_W-1:0] mv_beat_t;

    typedef struct packed {
        logic     v;
        mv_core_t core;
        mv_addr_t addr;    // base, wraps
        mv_beat_t data;
    } mv_load_t;

    // broadcast to every core
    typedef struct packed {
        logic     init;
        logic     exec;
        logic     update;
        logic     out_period;
        mv_addr_t addr;
    } mv_exec_t;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        EXEC,
        DRAIN,
        SHIFT
    } mv_state_t;

endpackage

`default_nettype wire

/* logic/mac_core.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mv_defs.svh"

module mac_core (
    input  logic             clk,
    input  logic             rst_n,
    input  mv_pkg::mv_load_t load,
    input  mv_pkg::mv_core_t core_id,
    input  mv_pkg::mv_exec_t ctl,
    input  mv_pkg::mv_word_t exec_src_data,
    input  mv_pkg::mv_word_t acc_next,
    output mv_pkg::mv_word_t acc
);
    import mv_pkg::*;

    mv_word_t weights [`MV_DEPTH];
    mv_word_t w_fetch;      // stage 1
    mv_word_t prod;         // stage 2
    mv_word_t acc_left;
    mv_word_t acc_right;    // readout shift stage
    logic     init_d1;
    logic     init_d2;
    logic     exec_d1;
    logic     exec_d2;
    logic     load_hit;

    assign load_hit = load.v && (load.core == core_id);

    // one beat lands on consecutive words of the row
    always_ff @(posedge clk) begin
        if (load_hit) begin
            for (int i = 0; i < `MV_BEAT_WORDS; i++) begin
                weights[load.addr + mv_addr_t'(i)] <= load.data[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_d1 <= 1'b0;
            init_d2 <= 1'b0;
            exec_d1 <= 1'b0;
            exec_d2 <= 1'b0;
        end else begin
            init_d1 <= ctl.init;
            init_d2 <= init_d1;
            exec_d1 <= ctl.exec;
            exec_d2 <= exec_d1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.exec) begin
            w_fetch <= weights[ctl.addr];
        end
        if (exec_d1) begin
            prod <= w_fetch * exec_src_data;    // vector word arrives now
        end
    end

    always_ff @(posedge clk) begin
        if (init_d2) begin
            acc_left <= '0;
        end else if (exec_d2) begin
            acc_left <= acc_left + prod;    // wraps mod 2^32
        end
        if (ctl.out_period) begin
            acc_right <= acc_next;
        end
    end

    // own sum on the update cycle, downstream values after it
    assign acc = ctl.update ? acc_left : acc_right;

endmodule

`default_nettype wire

/* logic/vec_buffer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mv_defs.svh"

module vec_buffer (
    input  logic             clk,
    input  logic             vec_v,
    input  mv_pkg::mv_addr_t vec_a,
    input  mv_pkg::mv_word_t vec_d,
    input  mv_pkg::mv_exec_t ctl,
    output mv_pkg::mv_word_t rd_data
);
    import mv_pkg::*;

    mv_word_t vec_mem [`MV_DEPTH];

    always_ff @(posedge clk) begin
        if (vec_v) begin
            vec_mem[vec_a] <= vec_d;
        end
    end

    // lines up with the weight fetch stage in each core
    always_ff @(posedge clk) begin
        if (ctl.exec) begin
            rd_data <= vec_mem[ctl.addr];
        end
    end

endmodule

`default_nettype wire

/* logic/step_counter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mv_defs.svh"

module step_counter (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic [$clog2(`MV_DEPTH):0] count,
    input  logic                       en,
    output mv_pkg::mv_addr_t           value,
    output logic                       zero
);

    logic [$clog2(`MV_DEPTH):0] remain;    // steps left after this one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
            value  <= '0;
        end else if (load) begin
            remain <= count - 1'b1;
            value  <= '0;
        end else if (en) begin
            if (remain != '0) begin
                remain <= remain - 1'b1;    // holds at zero
            end
            value <= value + 1'b1;
        end
    end

    assign zero = (remain == '0);    // last cycle of the phase

endmodule

`default_nettype wire

/* logic/mv_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mv_defs.svh"

module mv_ctrl (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [$clog2(`MV_DEPTH):0] len,
    input  logic                       cnt_zero,
    input  mv_pkg::mv_addr_t           cnt_value,
    output logic                       cnt_load,
    output logic [$clog2(`MV_DEPTH):0] cnt_count,
    output logic                       cnt_en,
    output mv_pkg::mv_exec_t           ctl,
    output logic                       busy,
    output logic                       result_v,
    output mv_pkg::mv_state_t          state
);
    import mv_pkg::*;

    // covers the 2 cycle init delay and the last product
    localparam logic [$clog2(`MV_DEPTH):0] DRAIN_COUNT = 3;
    localparam logic [$clog2(`MV_DEPTH):0] SHIFT_COUNT = `MV_CORES;

    mv_state_t state_nxt;
    logic      update_q;

    always_comb begin
        state_nxt = state;
        cnt_load  = 1'b0;
        cnt_count = len;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = INIT;
                end
            end
            INIT: begin
                cnt_load  = 1'b1;    // exec runs len steps
                state_nxt = EXEC;
            end
            EXEC: begin
                if (cnt_zero) begin
                    cnt_load  = 1'b1;
                    cnt_count = DRAIN_COUNT;
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (cnt_zero) begin
                    cnt_load  = 1'b1;
                    cnt_count = SHIFT_COUNT;
                    state_nxt = SHIFT;
                end
            end
            SHIFT: begin
                if (cnt_zero) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    assign cnt_en = (state == EXEC) || (state == DRAIN) || (state == SHIFT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            update_q <= 1'b0;
        end else begin
            state    <= state_nxt;
            update_q <= (state == DRAIN) && cnt_zero;    // first shift cycle
        end
    end

    always_comb begin
        ctl.init       = (state == INIT);
        ctl.exec       = (state == EXEC);
        ctl.update     = update_q;
        ctl.out_period = (state == SHIFT);
        ctl.addr       = cnt_value;    // step index during exec
    end

    assign busy     = (state != IDLE);
    assign result_v = (state == SHIFT);

endmodule

`default_nettype wire

/* logic/mv_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mv_defs.svh"

module mv_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mv_pkg::mv_load_t           load,
    input  logic                       vec_v,
    input  mv_pkg::mv_addr_t           vec_a,
    input  mv_pkg::mv_word_t           vec_d,
    input  logic                       start,
    input  logic [$clog2(`MV_DEPTH):0] len,
    output logic                       busy,
    output logic                       result_v,
    output mv_pkg::mv_word_t           result
);
    import mv_pkg::*;

    mv_exec_t                   ctl;
    mv_word_t                   exec_src_data;
    logic                       cnt_load;
    logic                       cnt_en;
    logic                       cnt_zero;
    logic [$clog2(`MV_DEPTH):0] cnt_count;
    mv_addr_t                   cnt_value;
    mv_word_t                   acc_chain [`MV_CORES+1];

    mv_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .len       (len),
        .cnt_zero  (cnt_zero),
        .cnt_value (cnt_value),
        .cnt_load  (cnt_load),
        .cnt_count (cnt_count),
        .cnt_en    (cnt_en),
        .ctl       (ctl),
        .busy      (busy),
        .result_v  (result_v),
        .state     ()
    );

    step_counter u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (cnt_load),
        .count (cnt_count),
        .en    (cnt_en),
        .value (cnt_value),
        .zero  (cnt_zero)
    );

    vec_buffer u_vec (
        .clk     (clk),
        .vec_v   (vec_v),
        .vec_a   (vec_a),
        .vec_d   (vec_d),
        .ctl     (ctl),
        .rd_data (exec_src_data)
    );

    assign acc_chain[`MV_CORES] = '0;    // tail of the readout chain

    for (genvar i = 0; i < `MV_CORES; i++) begin : g_core
        mac_core u_core (
            .clk           (clk),
            .rst_n         (rst_n),
            .load          (load),
            .core_id       (mv_core_t'(i)),
            .ctl           (ctl),
            .exec_src_data (exec_src_data),
            .acc_next      (acc_chain[i+1]),
            .acc           (acc_chain[i])
        );
    end

    assign result = acc_chain[0];

endmodule

`default_nettype wire

/* test/mv_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module mv_assertions (
    input logic              clk,
    input logic              rst_n,
    input mv_pkg::mv_exec_t  ctl,
    input logic              result_v,
    input mv_pkg::mv_state_t state
);
    import mv_pkg::*;

    update_in_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctl.update |-> ctl.out_period
    ) else $error("update high without out_period");

    exec_in_exec: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctl.exec |-> (state == EXEC)
    ) else $error("exec high outside the EXEC state");

    valid_in_shift: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_v |-> (state == SHIFT)
    ) else $error("result_v high outside the SHIFT state");

endmodule

bind mv_ctrl mv_assertions u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctl      (ctl),
    .result_v (result_v),
    .state    (state)
);

`default_nettype wire

/* test/mv_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mv_defs.svh"

module mv_tb;
    import mv_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int LEN_W       = $clog2(`MV_DEPTH) + 1;
    localparam int RAND_RUNS   = 6;
    localparam int NUM_RUNS    = RAND_RUNS + 1;
    localparam int EXTRA_BEATS = 6;
    localparam int RUN_CYCLES  = NUM_RUNS * (`MV_DEPTH + `MV_CORES + 10);
    localparam int LOAD_CYCLES = `MV_CORES * (`MV_DEPTH / `MV_BEAT_WORDS) + EXTRA_BEATS + 1
                                 + NUM_RUNS * `MV_DEPTH + 10;

    logic             clk;
    logic             rst_n;
    mv_load_t         load;
    logic             vec_v;
    mv_addr_t         vec_a;
    mv_word_t         vec_d;
    logic             start;
    logic [LEN_W-1:0] len;
    logic             busy;
    logic             result_v;
    mv_word_t         result;

    logic [31:0] lfsr_state;
    mv_word_t    model_w [`MV_CORES][`MV_DEPTH];
    mv_word_t    model_v [`MV_DEPTH];
    mv_word_t    exp_sum [`MV_CORES];

    mv_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .vec_v    (vec_v),
        .vec_a    (vec_a),
        .vec_d    (vec_d),
        .start    (start),
        .len      (len),
        .busy     (busy),
        .result_v (result_v),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_result(input mv_word_t got, input mv_word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s, got %h expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s, busy %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t ns: %s, result_v %b expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic write_beat(input mv_core_t core, input mv_addr_t base);
        mv_beat_t beat;
        for (int k = 0; k < `MV_BEAT_WORDS; k++) begin
            beat[k] = rand_bits(`MV_WORD_W);
            model_w[core][base + mv_addr_t'(k)] = beat[k];    // row wraps
        end
        check_busy(busy, 1'b0, "busy during weight load");
        check_valid(result_v, 1'b0, "result_v during weight load");
        load.v    = 1'b1;
        load.core = core;
        load.addr = base;
        load.data = beat;
        @(negedge clk);
        load.v = 1'b0;
    endtask

    task automatic load_all_weights();
        mv_addr_t base;
        for (int c = 0; c < `MV_CORES; c++) begin
            base = mv_addr_t'(rand_bits(6));
            for (int b = 0; b < `MV_DEPTH / `MV_BEAT_WORDS; b++) begin
                write_beat(mv_core_t'(c), base + mv_addr_t'(b * `MV_BEAT_WORDS));
            end
        end
        write_beat(mv_core_t'(rand_bits(2)), mv_addr_t'(59));    // crosses the top
        for (int e = 0; e < EXTRA_BEATS; e++) begin
            write_beat(mv_core_t'(rand_bits(2)), mv_addr_t'(rand_bits(6)));
        end
    endtask

    task automatic write_vector();
        for (int j = 0; j < `MV_DEPTH; j++) begin
            check_busy(busy, 1'b0, "busy during vector write");
            check_valid(result_v, 1'b0, "result_v during vector write");
            vec_v      = 1'b1;
            vec_a      = mv_addr_t'(j);
            vec_d      = rand_bits(`MV_WORD_W);
            model_v[j] = vec_d;
            @(negedge clk);
        end
        vec_v = 1'b0;
    endtask

    // dot product of the first run_len words, mod 2^32
    task automatic model_sums(input int run_len);
        for (int c = 0; c < `MV_CORES; c++) begin
            exp_sum[c] = '0;
            for (int j = 0; j < run_len; j++) begin
                exp_sum[c] = exp_sum[c] + model_w[c][j] * model_v[j];
            end
        end
    endtask

    task automatic run_and_check(input int run_len, input logic poke_start);
        int waited;
        model_sums(run_len);
        check_busy(busy, 1'b0, "busy before start");
        start = 1'b1;
        len   = LEN_W'(run_len);
        @(negedge clk);
        start = 1'b0;
        check_busy(busy, 1'b1, "busy the cycle after start");
        waited = 0;
        while (result_v !== 1'b1) begin
            if (waited > run_len + 20) begin
                abort_run($sformatf("result_v never rose for a run of length %0d", run_len));
            end
            check_busy(busy, 1'b1, "busy while running");
            start = poke_start && (waited == 2);    // stray start mid run
            @(negedge clk);
            waited++;
        end
        start = 1'b0;
        for (int k = 0; k < `MV_CORES; k++) begin
            check_valid(result_v, 1'b1, $sformatf("result_v in slot %0d", k));
            check_result(result, exp_sum[k], $sformatf("core %0d sum, len %0d", k, run_len));
            @(negedge clk);
        end
        check_valid(result_v, 1'b0, "result_v after last slot");
        check_busy(busy, 1'b0, "busy after last slot");
        @(negedge clk);
        check_busy(busy, 1'b0, "busy one cycle after run");
    endtask

    initial begin
        lfsr_state = 32'd94594;
        rst_n      = 1'b0;
        start      = 1'b0;
        len        = LEN_W'(1);
        load       = '0;
        vec_v      = 1'b0;
        vec_a      = '0;
        vec_d      = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_busy(busy, 1'b0, "busy after reset");
            check_valid(result_v, 1'b0, "result_v after reset");
        end
        load_all_weights();
        write_vector();
        run_and_check(`MV_DEPTH, 1'b0);
        for (int r = 0; r < RAND_RUNS; r++) begin
            write_vector();    // weights stay as loaded
            run_and_check(int'(rand_bits(6)) + 1, r == 2);
        end
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #((RUN_CYCLES + LOAD_CYCLES) * CLK_PERIOD * 2);
        abort_run("timeout: the test sequence did not finish in the expected time");
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/mv_pkg.sv
logic/mac_core.sv
logic/vec_buffer.sv
logic/step_counter.sv
logic/mv_ctrl.sv
logic/mv_top.sv
test/mv_assertions.sv
test/mv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mv_tb simulation with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mv_tb -f src.f -o mv_sim \
    && ./obj_dir/mv_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "TEST PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
